// ==== list.f ====
hdl/renamePkg.sv
hdl/freeIf.sv
hdl/mapIf.sv
hdl/freeList.sv
hdl/mapTable.sv
hdl/reorderBuffer.sv
hdl/renameTop.sv
bench/renameBench.sv

// ==== Makefile ====
BUILD := build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module renameBench -Mdir $(BUILD) -f list.f
	@out="$$(./$(BUILD)/VrenameBench)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILD)

// ==== bench/renameBench.sv ====
`timescale 1ns/1ns

module renameBench import renamePkg::*; ();

  // roughly four times the expected run length
  localparam int timeoutCycles = 2000;
  localparam int rounds = 40;

  typedef struct packed {
    archReg  dest;
    physTag  tag;
    physTag  oldTag;
    logic    halt;
    robIndex idx;
    logic    done;
  } modelEntry;

  logic    clock = 1'b0;
  logic    reset = 1'b1;
  logic    decodeValid = 1'b0;
  archReg  decodeDest = '0;
  logic    decodeHalt = 1'b0;
  logic    completeValid = 1'b0;
  robIndex completeIdx = '0;
  logic    decodeReady;
  physTag  dispatchTag;
  physTag  dispatchOldTag;
  robIndex dispatchIdx;
  logic    retireValid;
  archReg  retireDest;
  physTag  retireTag;
  physTag  retireOldTag;
  logic    haltOut;

  // reference model state
  physTag      freeQ [$];
  modelEntry   robQ [$];
  physTag      mapModel [numArch];
  robIndex     tailIdx;
  logic        halted;
  int          dispatchCount;
  int          retireCount;
  int          cycleCount = 0;
  logic [31:0] rngState = 32'd18377;
  robIndex     pending [$];

  // what the DUT should show in the current cycle
  logic      expReady;
  physTag    expFreeHead;
  robIndex   expTailIdx;
  logic      expRetire;
  modelEntry expHead;
  physTag    expOldTag;
  logic      transfer;

  renameTop dut_i (.*);

  always #5 clock = ~clock;

  assign transfer  = decodeValid && decodeReady;
  assign expOldTag = mapModel[decodeDest];

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    $display("Checks failed");
    $fatal(1, "mismatch on %s", name);
  endtask

  // model steps on the same edge as the DUT, exports go out through NBA
  always @(posedge clock) begin
    modelEntry entry;
    if (reset) begin
      freeQ.delete();
      robQ.delete();
      for (int i = 0; i < numFree; i++) begin
        freeQ.push_back(physTag'(numArch + i));
      end
      for (int i = 0; i < numArch; i++) begin
        mapModel[i] <= physTag'(i);
      end
      tailIdx = '0;
      halted = 1'b0;
      dispatchCount = 0;
      retireCount = 0;
    end else begin
      // head retires only on a completion from an earlier edge
      if (robQ.size() > 0 && robQ[0].done) begin
        freeQ.push_back(robQ[0].oldTag);
        halted = halted || robQ[0].halt;
        void'(robQ.pop_front());
        retireCount++;
      end
      if (completeValid) begin
        foreach (robQ[i]) begin
          if (robQ[i].idx == completeIdx) robQ[i].done = 1'b1;
        end
      end
      if (decodeValid && expReady) begin
        entry.dest   = decodeDest;
        entry.tag    = freeQ.pop_front();
        entry.oldTag = mapModel[decodeDest];
        entry.halt   = decodeHalt;
        entry.idx    = tailIdx;
        entry.done   = 1'b0;
        robQ.push_back(entry);
        mapModel[decodeDest] <= entry.tag;
        tailIdx = tailIdx + robIndex'(1);
        dispatchCount++;
      end
    end
    expReady    <= freeQ.size() > 0 && robQ.size() < numRob && !halted;
    expFreeHead <= (freeQ.size() > 0) ? freeQ[0] : '0;
    expTailIdx  <= tailIdx;
    expRetire   <= robQ.size() > 0 && robQ[0].done;
    expHead     <= (robQ.size() > 0) ? robQ[0] : '0;
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  readyCheck: assert property (@(posedge clock) disable iff (reset) decodeReady == expReady)
    else reportMismatch("decodeReady", 32'($sampled(expReady)), 32'($sampled(decodeReady)));
  tagCheck: assert property (@(posedge clock) disable iff (reset)
    transfer |-> dispatchTag == expFreeHead)
    else reportMismatch("dispatchTag", 32'($sampled(expFreeHead)), 32'($sampled(dispatchTag)));
  oldTagCheck: assert property (@(posedge clock) disable iff (reset)
    transfer |-> dispatchOldTag == expOldTag)
    else reportMismatch("dispatchOldTag", 32'($sampled(expOldTag)),
                        32'($sampled(dispatchOldTag)));
  idxCheck: assert property (@(posedge clock) disable iff (reset)
    transfer |-> dispatchIdx == expTailIdx)
    else reportMismatch("dispatchIdx", 32'($sampled(expTailIdx)), 32'($sampled(dispatchIdx)));
  retireCheck: assert property (@(posedge clock) disable iff (reset) retireValid == expRetire)
    else reportMismatch("retireValid", 32'($sampled(expRetire)), 32'($sampled(retireValid)));
  retireDestCheck: assert property (@(posedge clock) disable iff (reset)
    retireValid |-> retireDest == expHead.dest)
    else reportMismatch("retireDest", 32'($sampled(expHead.dest)), 32'($sampled(retireDest)));
  retireTagCheck: assert property (@(posedge clock) disable iff (reset)
    retireValid |-> retireTag == expHead.tag)
    else reportMismatch("retireTag", 32'($sampled(expHead.tag)), 32'($sampled(retireTag)));
  retireOldCheck: assert property (@(posedge clock) disable iff (reset)
    retireValid |-> retireOldTag == expHead.oldTag)
    else reportMismatch("retireOldTag", 32'($sampled(expHead.oldTag)),
                        32'($sampled(retireOldTag)));
  haltCheck: assert property (@(posedge clock) disable iff (reset)
    haltOut == (expRetire && expHead.halt))
    else reportMismatch("haltOut", 32'($sampled(expRetire && expHead.halt)),
                        32'($sampled(haltOut)));

  // holds decodeValid until the DUT takes one instruction
  task automatic dispatchOne(input logic halt);
    decodeValid = 1'b1;
    decodeDest  = archReg'(nextRand());
    decodeHalt  = halt;
    while (!decodeReady) @(negedge clock);
    pending.push_back(dispatchIdx);
    @(negedge clock);
  endtask

  task automatic completeShuffled();
    int k;
    while (pending.size() > 0) begin
      k = int'(nextRand() % 32'(pending.size()));
      completeValid = 1'b1;
      completeIdx   = pending[k];
      pending.delete(k);
      @(negedge clock);
    end
    completeValid = 1'b0;
  endtask

  task automatic waitDrained();
    while (retireCount != dispatchCount) @(negedge clock);
  endtask

  initial begin
    int accepted;
    int batch;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    // random batches, tags recycle across rounds
    repeat (rounds) begin
      batch = int'(nextRand() % 32'd8) + 1;
      repeat (batch) dispatchOne(1'b0);
      decodeValid = 1'b0;
      completeShuffled();
      waitDrained();
    end
    // nothing completes, so the buffer fills up
    accepted = 0;
    decodeValid = 1'b1;
    decodeDest  = archReg'(nextRand());
    repeat (numRob + 4) begin
      if (decodeReady) begin
        accepted++;
        pending.push_back(dispatchIdx);
      end
      @(negedge clock);
    end
    if (accepted != numRob) begin
      reportMismatch("accepted transfers", 32'(numRob), 32'(accepted));
    end
    // oldest entry retires and frees one slot
    completeValid = 1'b1;
    completeIdx   = pending.pop_front();
    @(negedge clock);
    completeValid = 1'b0;
    while (!decodeReady) @(negedge clock);
    pending.push_back(dispatchIdx);
    @(negedge clock);
    decodeValid = 1'b0;
    completeShuffled();
    waitDrained();
    // halt retires, then decode stays blocked
    dispatchOne(1'b0);
    dispatchOne(1'b1);
    decodeValid = 1'b0;
    decodeHalt  = 1'b0;
    completeShuffled();
    waitDrained();
    decodeValid = 1'b1;
    repeat (10) @(negedge clock);
    decodeValid = 1'b0;
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== hdl/renameTop.sv ====
`timescale 1ns/1ns

module renameTop import renamePkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    decodeValid,
  input  archReg  decodeDest,
  input  logic    decodeHalt,
  input  logic    completeValid,
  input  robIndex completeIdx,
  output logic    decodeReady,
  output physTag  dispatchTag,
  output physTag  dispatchOldTag,
  output robIndex dispatchIdx,
  output logic    retireValid,
  output archReg  retireDest,
  output physTag  retireTag,
  output physTag  retireOldTag,
  output logic    haltOut
);

  freeIf freeBus ();
  mapIf  mapBus ();

  freeList freeListInst (
    .clock (clock),
    .reset (reset),
    .free  (freeBus.provider)
  );

  mapTable mapTableInst (
    .clock (clock),
    .reset (reset),
    .map   (mapBus.provider)
  );

  reorderBuffer robInst (
    .clock          (clock),
    .reset          (reset),
    .decodeValid    (decodeValid),
    .decodeHalt     (decodeHalt),
    .completeValid  (completeValid),
    .decodeDest     (decodeDest),
    .completeIdx    (completeIdx),
    .free           (freeBus.consumer),
    .map            (mapBus.consumer),
    .decodeReady    (decodeReady),
    .retireValid    (retireValid),
    .haltOut        (haltOut),
    .dispatchTag    (dispatchTag),
    .dispatchOldTag (dispatchOldTag),
    .retireTag      (retireTag),
    .retireOldTag   (retireOldTag),
    .dispatchIdx    (dispatchIdx),
    .retireDest     (retireDest)
  );

endmodule

// ==== hdl/reorderBuffer.sv ====
`timescale 1ns/1ns

module reorderBuffer import renamePkg::*; (
  input  logic    clock,
  input  logic    reset,
  input  logic    decodeValid,
  input  logic    decodeHalt,
  input  logic    completeValid,
  input  archReg  decodeDest,
  input  robIndex completeIdx,
  freeIf.consumer free,
  mapIf.consumer  map,
  output logic    decodeReady,
  output logic    retireValid,
  output logic    haltOut,
  output physTag  dispatchTag,
  output physTag  dispatchOldTag,
  output physTag  retireTag,
  output physTag  retireOldTag,
  output robIndex dispatchIdx,
  output archReg  retireDest
);

  robEntry rob [numRob];
  robIndex head;
  robIndex tail;
  logic    halted;
  logic    transfer;
  robEntry headEntry;

  assign headEntry = rob[head];

  // dispatch side
  assign decodeReady = free.tagValid && !rob[tail].valid && !halted;
  assign transfer    = decodeValid && decodeReady;

  assign free.take  = transfer;
  assign map.dest   = decodeDest;
  assign map.write  = transfer;
  assign map.newTag = free.headTag;

  assign dispatchTag    = free.headTag;
  assign dispatchOldTag = map.oldTag;
  assign dispatchIdx    = tail;

  // retire side, head only, no stall
  assign retireValid  = headEntry.valid && headEntry.complete;
  assign retireDest   = headEntry.dest;
  assign retireTag    = headEntry.tag;
  assign retireOldTag = headEntry.oldTag;
  assign haltOut      = retireValid && headEntry.halt;

  assign free.releaseValid = retireValid;
  assign free.releaseTag   = headEntry.oldTag;
  assign map.retire        = retireValid;
  assign map.retireDest    = headEntry.dest;
  assign map.retireTag     = headEntry.tag;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < numRob; i++) begin
        rob[i].valid    <= 1'b0;
        rob[i].complete <= 1'b0;
      end
    end else begin
      // stale indices are dropped
      if (completeValid && rob[completeIdx].valid) begin
        rob[completeIdx].complete <= 1'b1;
      end
      if (retireValid) begin
        rob[head].valid <= 1'b0;
      end
      // tail is never the retiring head, since it must be empty
      if (transfer) begin
        rob[tail].valid    <= 1'b1;
        rob[tail].complete <= 1'b0;
        rob[tail].halt     <= decodeHalt;
        rob[tail].dest     <= decodeDest;
        rob[tail].tag      <= free.headTag;
        rob[tail].oldTag   <= map.oldTag;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head   <= '0;
      tail   <= '0;
      halted <= 1'b0;
    end else begin
      if (transfer) begin
        tail <= tail + 1'b1;
      end
      if (retireValid) begin
        head <= head + 1'b1;
      end
      // sticky until reset
      if (haltOut) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

// ==== hdl/mapTable.sv ====
`timescale 1ns/1ns

module mapTable import renamePkg::*; (
  input logic    clock,
  input logic    reset,
  mapIf.provider map
);

  // speculative map, follows dispatch
  physTag specMap [numArch];

  // committed map, follows retirement
  physTag archMap [numArch];

  // previous mapping of the destination, before this cycle's write
  assign map.oldTag = specMap[map.dest];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < numArch; i++) begin
        specMap[i] <= physTag'(i);
      end
    end else if (map.write) begin
      specMap[map.dest] <= map.newTag;
    end
  end

  // restore point for a later rollback
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < numArch; i++) begin
        archMap[i] <= physTag'(i);
      end
    end else if (map.retire) begin
      archMap[map.retireDest] <= map.retireTag;
    end
  end

endmodule

// ==== hdl/freeList.sv ====
`timescale 1ns/1ns

module freeList import renamePkg::*; (
  input logic     clock,
  input logic     reset,
  freeIf.provider free
);

  physTag                     queue [numFree];
  logic [$clog2(numFree)-1:0] head;
  logic [$clog2(numFree)-1:0] tail;
  logic [$clog2(numFree):0]   count;
  logic                       pop;
  logic                       push;

  assign free.tagValid = (count != '0);
  assign free.headTag  = queue[head];

  // never pop an empty queue
  assign pop  = free.take && free.tagValid;
  assign push = free.releaseValid;

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the architectural range start out free
      for (int i = 0; i < numFree; i++) begin
        queue[i] <= physTag'(numArch + i);
      end
    end else if (push) begin
      queue[tail] <= free.releaseTag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      // full queue, so tail has wrapped back onto head
      tail  <= '0;
      count <= ($clog2(numFree) + 1)'(numFree);
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (push) begin
        tail <= tail + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hdl/mapIf.sv ====
`timescale 1ns/1ns

interface mapIf import renamePkg::*; ();

  // speculative lookup and update at dispatch
  archReg dest;
  logic   write;
  physTag newTag;
  physTag oldTag;

  // architectural update at retirement
  logic   retire;
  archReg retireDest;
  physTag retireTag;

  modport provider (
    input  dest, write, newTag, retire, retireDest, retireTag,
    output oldTag
  );

  modport consumer (
    output dest, write, newTag, retire, retireDest, retireTag,
    input  oldTag
  );

endinterface

// ==== hdl/freeIf.sv ====
`timescale 1ns/1ns

interface freeIf import renamePkg::*; ();

  logic   tagValid;
  physTag headTag;
  logic   take;
  logic   releaseValid;
  physTag releaseTag;

  modport provider (
    output tagValid, headTag,
    input  take, releaseValid, releaseTag
  );

  modport consumer (
    input  tagValid, headTag,
    output take, releaseValid, releaseTag
  );

endinterface

// ==== hdl/renamePkg.sv ====
package renamePkg;

  // register file and tag space sizes
  localparam int numArch = 16;
  localparam int numPhys = 32;
  localparam int numFree = numPhys - numArch;

  // in-flight window
  localparam int numRob = 8;

  typedef logic [$clog2(numArch)-1:0] archReg;
  typedef logic [$clog2(numPhys)-1:0] physTag;
  typedef logic [$clog2(numRob)-1:0] robIndex;

  // one reorder-buffer slot
  typedef struct packed {
    logic   valid;
    logic   complete;
    logic   halt;
    archReg dest;
    physTag tag;
    // mapping displaced by this instruction, freed at retirement
    physTag oldTag;
  } robEntry;

endpackage
